// File: src/ldpc_pkg.sv
`default_nettype none

package ldpc_pkg;

    localparam int ZC         = 2;    // lifting size, bits per circulant
    localparam int KB         = 10;   // information columns
    localparam int NUM_CORE   = 4;
    localparam int NUM_EXT    = 38;
    localparam int PUNCT_COLS = 2;    // leading info columns not transmitted
    localparam int INFO_BITS  = KB * ZC;
    localparam int CW_BITS    = 128;
    localparam int CW_USED    = INFO_BITS - PUNCT_COLS * ZC + NUM_CORE * ZC + NUM_EXT * ZC;

    // base graph entry
    typedef enum logic [1:0] {
        CIRC_NULL,  // no connection
        CIRC_ROT0,  // identity
        CIRC_ROT1   // rotate by one
    } circ_e;

    typedef logic [INFO_BITS-1:0]       info_t;  // column j at bits j*ZC upward
    typedef logic [NUM_CORE*ZC-1:0]     core_t;  // p0 lowest
    typedef logic [NUM_EXT*ZC-1:0]      ext_t;   // ext row 0 lowest
    typedef logic [CW_BITS-1:0]         codeword_t;

    // short names for the tables below
    localparam circ_e C_N = CIRC_NULL;
    localparam circ_e C_0 = CIRC_ROT0;
    localparam circ_e C_1 = CIRC_ROT1;

    localparam circ_e CORE_TABLE [NUM_CORE][KB] = '{
        '{C_1, C_1, C_0, C_0, C_N, C_N, C_1, C_N, C_N, C_1},
        '{C_1, C_N, C_N, C_0, C_1, C_1, C_0, C_0, C_0, C_0},
        '{C_1, C_0, C_N, C_0, C_0, C_N, C_N, C_N, C_0, C_N},
        '{C_N, C_0, C_0, C_N, C_0, C_0, C_1, C_0, C_0, C_0}
    };

    // extension rows over the information columns
    localparam circ_e EXT_INFO_TABLE [NUM_EXT][KB] = '{
        '{C_1, C_0, C_N, C_N, C_N, C_N, C_N, C_N, C_N, C_N},  // 0
        '{C_1, C_1, C_N, C_N, C_N, C_0, C_N, C_1, C_N, C_N},
        '{C_1, C_N, C_N, C_N, C_N, C_0, C_N, C_1, C_N, C_0},
        '{C_N, C_1, C_N, C_N, C_N, C_1, C_N, C_0, C_N, C_N},
        '{C_0, C_0, C_N, C_N, C_N, C_N, C_N, C_N, C_N, C_N},
        '{C_N, C_1, C_N, C_N, C_N, C_N, C_N, C_N, C_1, C_N},  // 5
        '{C_1, C_1, C_N, C_N, C_N, C_N, C_0, C_1, C_N, C_N},
        '{C_1, C_N, C_N, C_N, C_N, C_N, C_N, C_0, C_N, C_0},
        '{C_N, C_1, C_N, C_1, C_N, C_N, C_N, C_N, C_N, C_N},
        '{C_1, C_0, C_N, C_N, C_N, C_N, C_N, C_N, C_0, C_N},
        '{C_N, C_1, C_N, C_N, C_N, C_N, C_1, C_N, C_N, C_N},  // 10
        '{C_1, C_N, C_N, C_N, C_N, C_N, C_N, C_N, C_N, C_N},
        '{C_N, C_1, C_N, C_N, C_N, C_N, C_N, C_N, C_N, C_0},
        '{C_N, C_0, C_N, C_N, C_N, C_0, C_N, C_N, C_N, C_N},
        '{C_0, C_N, C_N, C_N, C_N, C_N, C_0, C_0, C_N, C_N},
        '{C_1, C_0, C_N, C_N, C_N, C_N, C_N, C_N, C_N, C_N},  // 15
        '{C_N, C_0, C_N, C_N, C_1, C_N, C_N, C_N, C_N, C_N},
        '{C_0, C_N, C_N, C_N, C_N, C_N, C_N, C_N, C_0, C_N},
        '{C_N, C_0, C_1, C_N, C_N, C_N, C_N, C_N, C_N, C_N},
        '{C_1, C_N, C_N, C_1, C_N, C_0, C_N, C_N, C_N, C_N},
        '{C_N, C_0, C_1, C_N, C_N, C_N, C_N, C_N, C_N, C_0},  // 20
        '{C_0, C_N, C_N, C_N, C_N, C_0, C_N, C_N, C_N, C_N},
        '{C_N, C_N, C_1, C_N, C_N, C_N, C_N, C_1, C_N, C_N},
        '{C_0, C_N, C_N, C_N, C_N, C_N, C_1, C_N, C_N, C_N},
        '{C_N, C_0, C_1, C_N, C_N, C_1, C_N, C_N, C_N, C_N},
        '{C_0, C_N, C_N, C_N, C_0, C_N, C_N, C_N, C_N, C_N},  // 25
        '{C_N, C_N, C_1, C_N, C_N, C_0, C_N, C_1, C_N, C_0},
        '{C_N, C_0, C_N, C_N, C_N, C_N, C_N, C_N, C_N, C_N},
        '{C_0, C_N, C_N, C_N, C_N, C_0, C_N, C_N, C_N, C_N},
        '{C_N, C_N, C_0, C_N, C_N, C_N, C_N, C_0, C_N, C_N},
        '{C_1, C_N, C_N, C_N, C_N, C_N, C_N, C_N, C_N, C_N},  // 30
        '{C_N, C_1, C_N, C_N, C_N, C_0, C_N, C_N, C_N, C_N},
        '{C_0, C_N, C_0, C_N, C_N, C_N, C_N, C_0, C_N, C_N},
        '{C_N, C_N, C_N, C_N, C_N, C_N, C_N, C_N, C_N, C_N},  // unconnected row
        '{C_N, C_1, C_N, C_N, C_N, C_0, C_N, C_N, C_N, C_N},
        '{C_1, C_N, C_N, C_N, C_N, C_N, C_N, C_0, C_N, C_N},  // 35
        '{C_N, C_N, C_0, C_N, C_N, C_N, C_N, C_N, C_N, C_N},
        '{C_N, C_1, C_N, C_N, C_N, C_1, C_N, C_N, C_N, C_N}
    };

    // extension rows over p0..p3
    localparam circ_e EXT_CORE_TABLE [NUM_EXT][NUM_CORE] = '{
        '{C_N, C_1, C_N, C_N}, '{C_N, C_1, C_N, C_N}, '{C_N, C_0, C_N, C_N},
        '{C_N, C_1, C_N, C_0}, '{C_N, C_N, C_0, C_N}, '{C_1, C_1, C_N, C_N},  // 0..5
        '{C_N, C_N, C_N, C_N}, '{C_N, C_N, C_N, C_0}, '{C_N, C_0, C_N, C_N},
        '{C_N, C_N, C_N, C_0}, '{C_N, C_1, C_N, C_0}, '{C_1, C_1, C_N, C_N},  // 6..11
        '{C_N, C_0, C_0, C_N}, '{C_N, C_0, C_0, C_N}, '{C_N, C_N, C_N, C_N},
        '{C_1, C_N, C_N, C_N}, '{C_N, C_1, C_N, C_N}, '{C_N, C_N, C_N, C_0},  // 12..17
        '{C_N, C_N, C_N, C_N}, '{C_N, C_N, C_N, C_N}, '{C_N, C_N, C_N, C_N},
        '{C_N, C_N, C_N, C_N}, '{C_N, C_N, C_0, C_0}, '{C_N, C_N, C_N, C_N},  // 18..23
        '{C_N, C_N, C_N, C_N}, '{C_N, C_N, C_N, C_N}, '{C_N, C_N, C_N, C_N},
        '{C_N, C_N, C_N, C_1}, '{C_N, C_N, C_0, C_N}, '{C_1, C_N, C_N, C_N},  // 24..29
        '{C_N, C_N, C_1, C_0}, '{C_N, C_1, C_N, C_N}, '{C_N, C_N, C_N, C_N},
        '{C_1, C_N, C_N, C_1}, '{C_N, C_0, C_N, C_N}, '{C_N, C_N, C_0, C_N},  // 30..35
        '{C_1, C_N, C_N, C_0}, '{C_N, C_0, C_N, C_N}                          // 36..37
    };

    // one circulant under one base graph entry: out[m] = in[(m + k) mod ZC]
    function automatic logic [ZC-1:0] rotate_circ(input logic [ZC-1:0] v, input circ_e e);
        logic [ZC-1:0] r;
        int            k;
        r = '0;
        k = (e == CIRC_ROT1) ? 1 : 0;
        if (e != CIRC_NULL) begin
            for (int m = 0; m < ZC; m++) begin
                r[m] = v[(m + k) % ZC];
            end
        end
        return r;
    endfunction

endpackage

`default_nettype wire

// File: src/row_parity_xor.sv
`default_nettype none

module row_parity_xor #(
    parameter int NUM_COLS = ldpc_pkg::KB
) (
    input  wire ldpc_pkg::circ_e             entries [NUM_COLS],
    input  wire logic [NUM_COLS*ldpc_pkg::ZC-1:0] cols,
    output logic [ldpc_pkg::ZC-1:0]          row_value
);
    import ldpc_pkg::*;

    // rotated copy of each column, NULL entries come back as zero
    logic [ZC-1:0] rotated [NUM_COLS];

    always_comb begin
        for (int c = 0; c < NUM_COLS; c++) begin
            rotated[c] = rotate_circ(cols[c*ZC +: ZC], entries[c]);
        end
    end

    always_comb begin
        row_value = '0;
        for (int c = 0; c < NUM_COLS; c++) begin
            row_value = row_value ^ rotated[c];  // mod-2 sum over the row
        end
    end

endmodule

`default_nettype wire

// File: src/core_parity_unit.sv
`default_nettype none

module core_parity_unit (
    input  wire logic       CLK,
    input  wire logic       RST,
    input  wire logic       start,
    input  wire logic [15:0] crc_bits,
    input  wire logic       data_bit,
    output logic            stage_valid,
    output ldpc_pkg::info_t stage_info,
    output ldpc_pkg::core_t stage_core
);
    import ldpc_pkg::*;

    info_t         info_word;
    logic [ZC-1:0] lambda [NUM_CORE];
    logic [ZC-1:0] lambda_sum;
    logic [ZC-1:0] p0;
    logic [ZC-1:0] p1;
    logic [ZC-1:0] p2;
    logic [ZC-1:0] p3;
    core_t         core_parity;

    // data bit lowest, crc above it, zero padding on top
    assign info_word = {{(INFO_BITS - 17){1'b0}}, crc_bits, data_bit};

    // core rows over the information columns
    for (genvar r = 0; r < NUM_CORE; r++) begin : g_core_row
        row_parity_xor #(
            .NUM_COLS (KB)
        ) u_row (
            .entries   (CORE_TABLE[r]),
            .cols      (info_word),
            .row_value (lambda[r])
        );
    end

    // dual diagonal solve
    assign lambda_sum = lambda[0] ^ lambda[1] ^ lambda[2] ^ lambda[3];
    assign p0 = rotate_circ(lambda_sum, CIRC_ROT1);
    assign p1 = p0 ^ lambda[0];
    assign p2 = p1 ^ lambda[1];
    assign p3 = p0 ^ lambda[3];  // lambda2 only enters through p0

    assign core_parity = {p3, p2, p1, p0};

    always_ff @(posedge CLK or negedge RST) begin
        if (!RST) begin
            stage_valid <= 1'b0;
        end else begin
            stage_valid <= start;  // single cycle per start
        end
    end

    // stage register, loaded only with a new word
    always_ff @(posedge CLK) begin
        if (start) begin
            stage_info <= info_word;
            stage_core <= core_parity;
        end
    end

    a_stage_valid_known: assert property (
        @(posedge CLK) disable iff (!RST) !$isunknown(stage_valid)
    );

endmodule

`default_nettype wire

// File: src/ext_parity_unit.sv
`default_nettype none

module ext_parity_unit (
    input  wire logic            CLK,
    input  wire logic            RST,
    input  wire logic            stage_valid,
    input  wire ldpc_pkg::info_t stage_info,
    input  wire ldpc_pkg::core_t stage_core,
    output ldpc_pkg::codeword_t  codeword,
    output logic                 valid
);
    import ldpc_pkg::*;

    logic [ZC-1:0] info_part [NUM_EXT];
    logic [ZC-1:0] core_part [NUM_EXT];
    ext_t          ext_parity;
    codeword_t     cw_next;

    for (genvar r = 0; r < NUM_EXT; r++) begin : g_ext_row
        row_parity_xor #(
            .NUM_COLS (KB)
        ) u_info (
            .entries   (EXT_INFO_TABLE[r]),
            .cols      (stage_info),
            .row_value (info_part[r])
        );

        row_parity_xor #(
            .NUM_COLS (NUM_CORE)
        ) u_core (
            .entries   (EXT_CORE_TABLE[r]),
            .cols      (stage_core),
            .row_value (core_part[r])
        );

        assign ext_parity[r*ZC +: ZC] = info_part[r] ^ core_part[r];
    end

    // punctured info, core parity, ext parity, zero fill on top
    assign cw_next = {
        {(CW_BITS - CW_USED){1'b0}},
        ext_parity,
        stage_core,
        stage_info[INFO_BITS-1:PUNCT_COLS*ZC]
    };

    always_ff @(posedge CLK or negedge RST) begin
        if (!RST) begin
            codeword <= '0;
            valid    <= 1'b0;
        end else begin
            valid <= stage_valid;
            if (stage_valid) begin
                codeword <= cw_next;  // otherwise hold last word
            end
        end
    end

    // output pulse only ever follows a staged word
    a_valid_after_stage: assert property (
        @(posedge CLK) disable iff (!RST) valid |-> $past(stage_valid)
    );

    a_pad_zero: assert property (
        @(posedge CLK) disable iff (!RST) codeword[CW_BITS-1:CW_USED] == '0
    );

endmodule

`default_nettype wire

// File: src/ldpc_encoder_top.sv
`default_nettype none

module ldpc_encoder_top (
    input  wire logic           CLK,
    input  wire logic           RST,
    input  wire logic [15:0]    crc_bits,
    input  wire logic           data_bit,
    input  wire logic           start,
    output ldpc_pkg::codeword_t codeword,
    output logic                valid
);
    import ldpc_pkg::*;

    // stage between core solve and extension rows
    logic  stage_valid;
    info_t stage_info;
    core_t stage_core;

    core_parity_unit u_core (
        .CLK         (CLK),
        .RST         (RST),
        .start       (start),
        .crc_bits    (crc_bits),
        .data_bit    (data_bit),
        .stage_valid (stage_valid),
        .stage_info  (stage_info),
        .stage_core  (stage_core)
    );

    ext_parity_unit u_ext (
        .CLK         (CLK),
        .RST         (RST),
        .stage_valid (stage_valid),
        .stage_info  (stage_info),
        .stage_core  (stage_core),
        .codeword    (codeword),
        .valid       (valid)
    );

endmodule

`default_nettype wire

// File: test/ldpc_ref_model.svh
`ifndef LDPC_REF_MODEL_SVH
`define LDPC_REF_MODEL_SVH

// one circulant under a base graph entry, out[m] = in[(m + k) mod ZC]
function automatic logic [ZC-1:0] rotate_by_entry(input logic [ZC-1:0] v, input circ_e e);
    logic [ZC-1:0] res;
    case (e)
        CIRC_ROT0: res = v;
        CIRC_ROT1: res = {v[0], v[ZC-1:1]};  // bit 0 wraps to the top
        default:   res = '0;
    endcase
    return res;
endfunction

function automatic logic [ZC-1:0] core_row_value(input info_t info, input int r);
    logic [ZC-1:0] acc;
    acc = '0;
    for (int c = 0; c < KB; c++) begin
        acc = acc ^ rotate_by_entry(info[c*ZC +: ZC], CORE_TABLE[r][c]);
    end
    return acc;
endfunction

// info part and core part of one extension row
function automatic logic [ZC-1:0] ext_row_value(input info_t info, input core_t core, input int r);
    logic [ZC-1:0] acc;
    acc = '0;
    for (int c = 0; c < KB; c++) begin
        acc = acc ^ rotate_by_entry(info[c*ZC +: ZC], EXT_INFO_TABLE[r][c]);
    end
    for (int c = 0; c < NUM_CORE; c++) begin
        acc = acc ^ rotate_by_entry(core[c*ZC +: ZC], EXT_CORE_TABLE[r][c]);
    end
    return acc;
endfunction

function automatic codeword_t model_codeword(input logic [15:0] crc, input logic d);
    info_t         info;
    logic [ZC-1:0] lam [NUM_CORE];
    logic [ZC-1:0] p [NUM_CORE];
    core_t         core;
    ext_t          ext;
    codeword_t     cw;
    info       = '0;
    info[0]    = d;
    info[16:1] = crc;  // top three bits stay zero
    for (int r = 0; r < NUM_CORE; r++) begin
        lam[r] = core_row_value(info, r);
    end
    p[0] = rotate_by_entry(lam[0] ^ lam[1] ^ lam[2] ^ lam[3], CIRC_ROT1);
    p[1] = p[0] ^ lam[0];
    p[2] = p[1] ^ lam[1];
    p[3] = p[0] ^ lam[3];
    for (int c = 0; c < NUM_CORE; c++) begin
        core[c*ZC +: ZC] = p[c];
    end
    for (int r = 0; r < NUM_EXT; r++) begin
        ext[r*ZC +: ZC] = ext_row_value(info, core, r);
    end
    cw = '0;
    for (int i = PUNCT_COLS * ZC; i < INFO_BITS; i++) begin
        cw[i - PUNCT_COLS*ZC] = info[i];  // punctured columns dropped
    end
    for (int i = 0; i < NUM_CORE * ZC; i++) begin
        cw[16 + i] = core[i];
    end
    for (int i = 0; i < NUM_EXT * ZC; i++) begin
        cw[24 + i] = ext[i];
    end
    return cw;
endfunction

`endif

// File: test/tb_ldpc_encoder.sv
`default_nettype none

module tb_ldpc_encoder;
    timeunit 1ns;
    timeprecision 100ps;

    import ldpc_pkg::*;

    `include "ldpc_ref_model.svh"

    localparam int N_FIXED     = 5;
    localparam int N_RANDOM    = 24;
    localparam int N_ENTRIES   = N_FIXED + N_RANDOM;
    localparam int CYCLE_LIMIT = N_ENTRIES * 4 + 40;

    logic        CLK;
    logic        RST;
    logic [15:0] crc_bits;
    logic        data_bit;
    logic        start;
    codeword_t   codeword;
    logic        valid;

    // stimulus table
    logic [15:0] tab_crc  [N_ENTRIES];
    logic        tab_data [N_ENTRIES];
    int          tab_gap  [N_ENTRIES];
    codeword_t   tab_cw   [N_ENTRIES];

    int          cur_idx;
    int          exp_q [$];          // table rows waiting for their valid
    logic [1:0]  valid_pipe;         // expected valid, two cycles behind start
    codeword_t   last_cw;
    int          cycle_count;
    int          start_count;
    int          valid_count;
    int          value_errors;
    int          other_errors;

    ldpc_encoder_top dut0 (
        .CLK      (CLK),
        .RST      (RST),
        .crc_bits (crc_bits),
        .data_bit (data_bit),
        .start    (start),
        .codeword (codeword),
        .valid    (valid)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x;
        y = y ^ (y << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic report_mismatch(input string name, input logic [CW_BITS-1:0] got,
                                   input logic [CW_BITS-1:0] exp);
        $display("[ERROR] %0t %s: got %0h expected %0h", $time, name, got, exp);
        value_errors++;
    endtask

    initial CLK = 1'b0;
    always #5 CLK = ~CLK;

    // timeout and start bookkeeping on the rising edge
    always @(posedge CLK) begin
        cycle_count++;
        if (RST && start) begin
            exp_q.push_back(cur_idx);
            start_count++;
        end
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("timeout after %0d cycles, DUT stopped producing codewords", cycle_count);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    always @(posedge CLK or negedge RST) begin
        if (!RST) begin
            valid_pipe <= 2'b00;
        end else begin
            valid_pipe <= {valid_pipe[0], start};
        end
    end

    // outputs are registered, so the falling edge sees them settled
    always @(negedge CLK) begin : monitor
        int idx;
        if (valid !== valid_pipe[1]) begin
            report_mismatch("valid", valid, valid_pipe[1]);
        end
        if (valid === 1'b1) begin
            valid_count++;
            if (exp_q.size() == 0) begin
                $display("valid pulse at %0t with no start waiting for it", $time);
                other_errors++;
            end else begin
                idx = exp_q.pop_front();
                if (codeword !== tab_cw[idx]) begin
                    report_mismatch("codeword", codeword, tab_cw[idx]);
                end
                if (codeword[12:0] !== tab_crc[idx][15:3]) begin
                    report_mismatch("codeword[12:0]", codeword[12:0], tab_crc[idx][15:3]);
                end
                if (codeword[15:13] !== 3'b000) begin
                    report_mismatch("codeword[15:13]", codeword[15:13], 3'b000);
                end
            end
            if (codeword[CW_BITS-1:CW_USED] !== '0) begin
                report_mismatch("codeword pad", codeword[CW_BITS-1:CW_USED], '0);
            end
            last_cw = codeword;
        end else if (codeword !== last_cw) begin
            report_mismatch("codeword held", codeword, last_cw);  // idle or reset
        end
    end

    initial begin
        logic [31:0] rnd;
        RST          = 1'b0;
        start        = 1'b0;
        crc_bits     = '0;
        data_bit     = 1'b0;
        cur_idx      = 0;
        last_cw      = '0;
        cycle_count  = 0;
        start_count  = 0;
        valid_count  = 0;
        value_errors = 0;
        other_errors = 0;

        // fixed rows: zeros, lone data bit, lone crc bits, all ones
        tab_crc[0] = 16'h0000;  tab_data[0] = 1'b0;
        tab_crc[1] = 16'h0000;  tab_data[1] = 1'b1;
        tab_crc[2] = 16'h0001;  tab_data[2] = 1'b0;
        tab_crc[3] = 16'h8000;  tab_data[3] = 1'b0;
        tab_crc[4] = 16'hffff;  tab_data[4] = 1'b1;
        for (int i = 0; i < N_FIXED; i++) begin
            tab_gap[i] = 3;  // isolated pulses
        end
        rnd = 32'hfb4a;
        for (int i = N_FIXED; i < N_ENTRIES; i++) begin
            rnd         = xorshift32(rnd);
            tab_crc[i]  = rnd[15:0];
            tab_data[i] = rnd[16];
            tab_gap[i]  = (i % 6 == 5) ? 2 : 0;  // mostly back to back
        end
        tab_cw[0] = '0;  // zero input encodes to zero
        for (int i = 1; i < N_ENTRIES; i++) begin
            tab_cw[i] = model_codeword(tab_crc[i], tab_data[i]);
        end

        repeat (5) @(posedge CLK);
        @(negedge CLK);
        RST = 1'b1;
        @(negedge CLK);

        for (int i = 0; i < N_ENTRIES; i++) begin
            cur_idx  = i;
            crc_bits = tab_crc[i];
            data_bit = tab_data[i];
            start    = 1'b1;
            @(negedge CLK);
            start = 1'b0;
            repeat (tab_gap[i]) @(negedge CLK);
        end
        start = 1'b0;

        while (exp_q.size() != 0) @(posedge CLK);
        repeat (3) @(negedge CLK);  // room for a stray pulse

        if (valid_count != start_count) begin
            $display("%0d starts were given but %0d valid pulses came out",
                     start_count, valid_count);
            other_errors++;
        end
        $display("value errors: %0d, other errors: %0d, codewords: %0d",
                 value_errors, other_errors, valid_count);
        if (value_errors == 0 && other_errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: filelist.f
+incdir+test
src/ldpc_pkg.sv
src/row_parity_xor.sv
src/core_parity_unit.sv
src/ext_parity_unit.sv
src/ldpc_encoder_top.sv
test/tb_ldpc_encoder.sv
